/* src.f */
+incdir+common
+incdir+verif
common/fraise_bus_pkg.sv
common/fraise_infer_pkg.sv
regs/fraise_regfile.sv
inference/fraise_sequencer.sv
decision/fraise_comparator.sv
decision/fraise_decision.sv
verilog/fraise_top.sv
verif/tb_clock_gen.sv
verif/fraise_tb.sv

/* Makefile */
# Verilator build of the inference controller testbench

OBJ_DIR = obj_dir
SIM     = fraise_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module fraise_tb -Mdir $(OBJ_DIR) -o $(SIM)

run: compile
	./$(OBJ_DIR)/$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* verif/fraise_tb_tasks.svh */
// bus access tasks, compare tasks, array reference helpers and directed tests
`ifndef FRAISE_TB_TASKS_SVH
`define FRAISE_TB_TASKS_SVH

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
endtask

task automatic check_resp(input string name, input bus_resp_t got, input logic [31:0] exp);
    bus_resp_t want;
    want = {exp, 1'b1};
    if (got !== want) begin
        report_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, want));
    end
endtask

task automatic check_results(input string name, input line_results_t got,
                             input line_results_t exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_decision(input string name, input decision_t got, input decision_t exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    end
endtask

// one bus access, returns the number of cycles the request waited
task automatic bus_access(input logic wen, input logic [31:0] addr, input logic [31:0] wdata,
                          output bus_resp_t resp, output int waited);
    waited = 0;
    bus_req = '{addr: addr, wen: wen, wdata: wdata, ben: 4'hF, host: 1'b1};
    req_valid = 1'b1;
    while (!ready) begin
        @(posedge clk);
        #1;
        waited++;
        check_flag("resp_valid_o while waiting", resp_valid, 1'b0);
    end
    @(posedge clk); // accepted here
    #1;
    req_valid = 1'b0;
    bus_req = '0;
    check_flag("resp_valid_o", resp_valid, 1'b1);
    resp = bus_resp;
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
    bus_resp_t resp;
    int waited;
    bus_access(1'b1, addr, wdata, resp, waited);
endtask

task automatic bus_read(input logic [31:0] addr, output bus_resp_t resp);
    int waited;
    bus_access(1'b0, addr, '0, resp, waited);
endtask

function automatic line_results_t expected_results(input obs_vec_t o);
    line_results_t r;
    for (int l = 0; l < `FRAISE_LINES; l++) begin
        r[l] = table_val[l][o[l]];
    end
    return r;
endfunction

function automatic logic expected_hit(input logic [7:0] op, input logic [7:0] res,
                                      input logic [7:0] ref_v, input logic [7:0] prec);
    int diff;
    diff = int'(res) - int'(ref_v);
    if (diff < 0) diff = -diff;
    case (op)
        8'd0: return diff <= int'(prec);
        8'd1: return res > ref_v;
        8'd2: return res < ref_v;
        default: return 1'b0;
    endcase
endfunction

task automatic wait_res_valid();
    bus_resp_t resp;
    do begin
        bus_read(`FRAISE_REG_RES_VALID, resp);
    end while (resp.data[0] !== 1'b1);
endtask

// program observations, launch once and wait for the result
task automatic run_inference(input obs_vec_t o);
    logic [31:0] word;
    word = '0;
    for (int l = 0; l < `FRAISE_LINES; l++) begin
        word[l*8 +: 3] = o[l];
    end
    exp_obs = o;
    rows_checked = 0;
    bus_write(`FRAISE_REG_OBS, word);
    bus_write(`FRAISE_REG_LAUNCH, 32'h1);
    wait_res_valid();
    if (rows_checked != `FRAISE_LINES) begin
        report_failure($sformatf("array model saw %0d line reads instead of 4", rows_checked));
    end
endtask

task automatic test_reset_regs();
    bus_resp_t resp;
    check_flag("ready_o", ready, 1'b1);
    check_flag("resp_valid_o", resp_valid, 1'b0);
    check_flag("irq_o", irq, 1'b0);
    bus_read(`FRAISE_REG_ON_OFF, resp);
    check_resp("ON_OFF", resp, 32'h0);
    bus_read(`FRAISE_REG_LAUNCH, resp);
    check_resp("LAUNCH", resp, 32'h0);
    bus_read(`FRAISE_REG_RES_VALID, resp);
    check_resp("RES_VALID", resp, 32'h0);
    bus_read(`FRAISE_REG_IRQ_EN, resp);
    check_resp("IRQ_EN", resp, 32'h0);
    bus_read(`FRAISE_REG_COMP_BYPASS, resp);
    check_resp("COMP_BYPASS", resp, 32'h0);
    bus_write(`FRAISE_REG_PRECISION, 32'h0403_0201);
    bus_write(`FRAISE_REG_COMP_REF, 32'hA5C3_7E19);
    bus_write(`FRAISE_REG_COMP_INSTR, 32'h0002_0100);
    bus_read(`FRAISE_REG_PRECISION, resp);
    check_resp("PRECISION", resp, 32'h0403_0201);
    bus_read(`FRAISE_REG_COMP_REF, resp);
    check_resp("COMP_REF", resp, 32'hA5C3_7E19);
    bus_read(`FRAISE_REG_COMP_INSTR, resp);
    check_resp("COMP_INSTR", resp, 32'h0002_0100);
    bus_write(`FRAISE_REG_RES, 32'hFFFF_FFFF); // read only
    bus_read(`FRAISE_REG_RES, resp);
    check_resp("RES", resp, 32'h0);
endtask

task automatic test_launch();
    bus_resp_t resp;
    obs_vec_t o;
    o = {3'd5, 3'd2, 3'd7, 3'd1};
    run_inference(o);
    bus_read(`FRAISE_REG_RES, resp);
    check_results("RES", line_results_t'(resp.data), expected_results(o));
    bus_read(`FRAISE_REG_RES_VALID, resp);
    check_resp("RES_VALID after RES read", resp, 32'h0);
endtask

task automatic test_compare_ops();
    bus_resp_t resp;
    line_results_t res;
    logic [31:0] ops;
    logic [31:0] refs;
    logic [31:0] precs;
    decision_t exp;
    res = expected_results(exp_obs);
    ops = {8'd1, 8'd2, 8'd0, 8'd0}; // lines 3..0
    for (int round = 0; round < 4; round++) begin
        for (int l = 0; l < `FRAISE_LINES; l++) begin
            refs[l*8 +: 8] = res[l] ^ (8'($random(seed)) & 8'h0F);
            precs[l*8 +: 8] = 8'($random(seed)) & 8'h0F;
        end
        bus_write(`FRAISE_REG_COMP_INSTR, ops);
        bus_write(`FRAISE_REG_COMP_REF, refs);
        bus_write(`FRAISE_REG_PRECISION, precs);
        for (int l = 0; l < `FRAISE_LINES; l++) begin
            exp[l] = expected_hit(ops[l*8 +: 8], res[l], refs[l*8 +: 8], precs[l*8 +: 8]);
        end
        bus_read(`FRAISE_REG_COMP_RESULT, resp);
        check_decision("COMP_RESULT", decision_t'(resp.data), exp);
        ops = {ops[23:0], ops[31:24]}; // rotate ops over lines
    end
endtask

task automatic test_min_max();
    bus_resp_t resp;
    decision_t exp_min;
    decision_t exp_max;
    table_val[0][6] = 8'd30;
    table_val[1][6] = 8'd90;
    table_val[2][6] = 8'd10;
    table_val[3][6] = 8'd60;
    for (int l = 0; l < `FRAISE_LINES; l++) begin
        table_val[l][7] = 8'h5A; // all tied
    end
    for (int pass = 0; pass < 2; pass++) begin
        exp_min = (pass == 0) ? 4'b0100 : 4'b0000; // line 2 lowest, ties mark none
        exp_max = (pass == 0) ? 4'b0010 : 4'b0000; // line 1 highest
        run_inference(pass == 0 ? {4{3'd6}} : {4{3'd7}});
        bus_read(`FRAISE_REG_RES, resp);
        check_results("RES", line_results_t'(resp.data), expected_results(exp_obs));
        bus_write(`FRAISE_REG_COMP_INSTR, 32'h0000_0003);
        bus_read(`FRAISE_REG_COMP_RESULT, resp);
        check_decision("COMP_RESULT min", decision_t'(resp.data), exp_min);
        bus_write(`FRAISE_REG_COMP_INSTR, 32'h0000_0004);
        bus_read(`FRAISE_REG_COMP_RESULT, resp);
        check_decision("COMP_RESULT max", decision_t'(resp.data), exp_max);
    end
endtask

task automatic test_interrupt();
    bus_resp_t resp;
    bus_write(`FRAISE_REG_COMP_REF, 32'h0);
    bus_write(`FRAISE_REG_IRQ_EN, 32'h1);
    bus_write(`FRAISE_REG_COMP_INSTR, 32'h0101_0101); // gt 0, non-zero decision
    run_inference({4{3'd6}});
    check_flag("irq_o after result", irq, 1'b1);
    bus_read(`FRAISE_REG_RES, resp);
    @(posedge clk);
    #1;
    check_flag("irq_o after RES read", irq, 1'b0);
    bus_write(`FRAISE_REG_COMP_INSTR, 32'h0202_0202); // lt 0, never true
    run_inference({4{3'd6}});
    check_flag("irq_o zero decision", irq, 1'b0);
    bus_write(`FRAISE_REG_COMP_BYPASS, 32'h1);
    @(posedge clk);
    #1;
    check_flag("irq_o bypass", irq, 1'b1);
    bus_read(`FRAISE_REG_RES, resp);
    bus_write(`FRAISE_REG_IRQ_EN, 32'h0);
    run_inference({4{3'd6}});
    repeat (3) @(posedge clk);
    #1;
    check_flag("irq_o disabled", irq, 1'b0);
    bus_read(`FRAISE_REG_RES, resp);
    bus_write(`FRAISE_REG_COMP_BYPASS, 32'h0);
endtask

task automatic test_continuous();
    bus_resp_t resp;
    int waited;
    int run_cycles;
    // busy cycles of one run: line reads, settle, capture and done
    run_cycles = `FRAISE_LINES * `FRAISE_READ_STEPS + `FRAISE_SETTLE_CYCLES
                 + `FRAISE_RES_W + 1;
    exp_obs = {3'd3, 3'd0, 3'd4, 3'd6};
    bus_write(`FRAISE_REG_OBS, 32'h0300_0406); // one observation per byte
    bus_write(`FRAISE_REG_ON_OFF, 32'h1);
    for (int run = 0; run < 2; run++) begin
        wait_res_valid();
        bus_read(`FRAISE_REG_RES, resp);
        check_results("RES continuous", line_results_t'(resp.data), expected_results(exp_obs));
    end
    // next run started with the RES read, hold a request inside it
    @(posedge clk);
    #1;
    check_flag("ready_o during run", ready, 1'b0);
    bus_access(1'b0, `FRAISE_REG_ON_OFF, '0, resp, waited);
    check_resp("ON_OFF held read", resp, 32'h1);
    if (waited != run_cycles - 1) begin
        report_failure($sformatf("request held during a run waited %0d cycles instead of %0d",
                                 waited, run_cycles - 1));
    end
    bus_write(`FRAISE_REG_ON_OFF, 32'h0);
    wait_res_valid();
    bus_read(`FRAISE_REG_RES, resp);
    check_results("RES last run", line_results_t'(resp.data), expected_results(exp_obs));
endtask

`endif

/* verif/fraise_tb.sv */
// testbench top: clock, reset, DUT, array model, watchdog and test order
`include "fraise_cfg.svh"

module fraise_tb;
    import fraise_bus_pkg::*;
    import fraise_infer_pkg::*;

    localparam int num_tests = 6;
    localparam int clk_period = 8;

    logic                     clk;
    logic                     counter_read_reset;
    logic                     req_valid;
    bus_req_t                 bus_req;
    logic                     ready;
    logic                     resp_valid;
    bus_resp_t                bus_resp;
    array_ctrl_t              array_ctrl;
    logic [`FRAISE_LINES-1:0] bit_out;
    logic                     irq;

    integer     seed;
    logic [7:0] table_val [`FRAISE_LINES][8]; // result per line and observation
    obs_vec_t   exp_obs;
    int         rows_checked;
    int         ro_cnt;
    int         pin_step; // cycles since csl, 0 outside a line read

    tb_clock_gen #(.period(clk_period)) u_clk (
        .clk_o (clk)
    );

    fraise_top dut_i (
        .clk_i              (clk),
        .counter_read_reset (counter_read_reset),
        .req_valid_i        (req_valid),
        .bus_req_i          (bus_req),
        .ready_o            (ready),
        .resp_valid_o       (resp_valid),
        .bus_resp_o         (bus_resp),
        .array_ctrl_o       (array_ctrl),
        .bit_out_i          (bit_out),
        .irq_o              (irq)
    );

    `include "fraise_tb_tasks.svh"

    // array model, looks at the pins just after each edge
    always @(posedge clk) begin
        int line;
        #1;
        line = int'(array_ctrl.addr_col >> 3);
        if (array_ctrl.instr == instr_read_mem) begin
            ro_cnt = 0;
            if (array_ctrl.csl && !counter_read_reset) begin
                if (array_ctrl.addr_row != {2'b00, exp_obs[line]}) begin
                    report_failure($sformatf("CHECK FAILED addr_row line %0d: got %h expected %h",
                                             line, array_ctrl.addr_row, exp_obs[line]));
                end
                rows_checked++;
            end
        end else begin
            ro_cnt++; // 1 based count of read_out cycles
        end
        // cwl high with csl and for two more cycles, low on the fourth
        if (array_ctrl.csl) begin
            pin_step = 1;
            check_flag("array_ctrl_o.cwl", array_ctrl.cwl, 1'b1);
        end else if (pin_step > 0) begin
            check_flag("array_ctrl_o.cwl", array_ctrl.cwl, pin_step != 3);
            pin_step = (pin_step == 3) ? 0 : pin_step + 1;
        end else begin
            check_flag("array_ctrl_o.cwl", array_ctrl.cwl, 1'b0);
        end
        for (int l = 0; l < `FRAISE_LINES; l++) begin
            if (ro_cnt >= 4 && ro_cnt <= 11) begin
                bit_out[l] = table_val[l][exp_obs[l]][11 - ro_cnt]; // msb first
            end else begin
                bit_out[l] = 1'b0;
            end
        end
    end

    // watchdog
    initial begin
        repeat (200 * num_tests) @(posedge clk);
        report_failure("run timed out before all tests completed");
    end

    initial begin
        seed = 32'h468e_4029;
        counter_read_reset = 1'b1;
        req_valid = 1'b0;
        bus_req = '0;
        bit_out = '0;
        exp_obs = '0;
        rows_checked = 0;
        ro_cnt = 0;
        pin_step = 0;
        for (int l = 0; l < `FRAISE_LINES; l++) begin
            for (int o = 0; o < 8; o++) begin
                table_val[l][o] = 8'($random(seed));
            end
        end
        repeat (5) @(posedge clk);
        #1;
        counter_read_reset = 1'b0;

        test_reset_regs();
        test_launch();
        test_compare_ops();
        test_min_max();
        test_interrupt();
        test_continuous();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
// testbench clock source
module tb_clock_gen #(
    parameter int period = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(period / 2) clk_o = ~clk_o; // free running

endmodule

/* verilog/fraise_top.sv */
// top level: register file, inference sequencer and decision block
`include "fraise_cfg.svh"

module fraise_top (
    input  logic                          clk_i,
    input  logic                          counter_read_reset,
    input  logic                          req_valid_i,
    input  fraise_bus_pkg::bus_req_t      bus_req_i,
    output logic                          ready_o,
    output logic                          resp_valid_o,
    output fraise_bus_pkg::bus_resp_t     bus_resp_o,
    output fraise_infer_pkg::array_ctrl_t array_ctrl_o,
    input  logic [`FRAISE_LINES-1:0]      bit_out_i,
    output logic                          irq_o
);
    import fraise_infer_pkg::*;

    logic          start;
    logic          busy;
    logic          done;
    logic          bypass;
    logic          irq_en;
    logic          res_valid;
    obs_vec_t      obs;
    line_results_t results;
    comp_cfg_t     comp_cfg;
    decision_t     decision;

    fraise_regfile u_regfile (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .req_valid_i        (req_valid_i),
        .bus_req_i          (bus_req_i),
        .busy_i             (busy),
        .done_i             (done),
        .results_i          (results),
        .decision_i         (decision),
        .ready_o            (ready_o),
        .resp_valid_o       (resp_valid_o),
        .bus_resp_o         (bus_resp_o),
        .start_o            (start),
        .obs_o              (obs),
        .comp_cfg_o         (comp_cfg),
        .bypass_o           (bypass),
        .irq_en_o           (irq_en),
        .res_valid_o        (res_valid)
    );

    fraise_sequencer u_sequencer (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .start_i            (start),
        .obs_i              (obs),
        .bit_out_i          (bit_out_i),
        .busy_o             (busy),
        .done_o             (done),
        .results_o          (results),
        .array_ctrl_o       (array_ctrl_o)
    );

    fraise_decision u_decision (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .results_i          (results),
        .comp_cfg_i         (comp_cfg),
        .bypass_i           (bypass),
        .irq_en_i           (irq_en),
        .res_valid_i        (res_valid),
        .decision_o         (decision),
        .irq_o              (irq_o)
    );

endmodule

/* decision/fraise_decision.sv */
// per-line comparators, strict min/max across lines, decision vector
// and the registered interrupt
`include "fraise_cfg.svh"

module fraise_decision (
    input  logic                            clk_i,
    input  logic                            counter_read_reset,
    input  fraise_infer_pkg::line_results_t results_i,
    input  fraise_infer_pkg::comp_cfg_t     comp_cfg_i,
    input  logic                            bypass_i,
    input  logic                            irq_en_i,
    input  logic                            res_valid_i,
    output fraise_infer_pkg::decision_t     decision_o,
    output logic                            irq_o
);
    import fraise_infer_pkg::*;

    decision_t hits;
    decision_t min_mask;
    decision_t max_mask;
    comp_op_e  mode;

    for (genvar g = 0; g < `FRAISE_LINES; g++) begin : g_comp
        fraise_comparator u_comp (
            .op_i        (comp_op_e'(comp_cfg_i.op[g])),
            .result_i    (results_i[g]),
            .reference_i (comp_cfg_i.reference[g]),
            .precision_i (comp_cfg_i.precision[g]),
            .hit_o       (hits[g])
        );
    end

    // a line wins only if strictly beyond every other line
    always_comb begin
        for (int i = 0; i < `FRAISE_LINES; i++) begin
            min_mask[i] = 1'b1;
            max_mask[i] = 1'b1;
            for (int j = 0; j < `FRAISE_LINES; j++) begin
                if (j != i) begin
                    if (results_i[i] >= results_i[j]) min_mask[i] = 1'b0;
                    if (results_i[i] <= results_i[j]) max_mask[i] = 1'b0;
                end
            end
        end
    end

    assign mode = comp_op_e'(comp_cfg_i.op[0]); // line 0 picks min/max for all

    assign decision_o = (mode == op_min) ? min_mask :
                        (mode == op_max) ? max_mask : hits;

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= res_valid_i && irq_en_i && (bypass_i || decision_o != '0);
        end
    end

endmodule

/* decision/fraise_comparator.sv */
// single line comparator: eq within precision, gt, lt
`include "fraise_cfg.svh"

module fraise_comparator (
    input  fraise_infer_pkg::comp_op_e op_i,
    input  logic [`FRAISE_RES_W-1:0]   result_i,
    input  logic [`FRAISE_RES_W-1:0]   reference_i,
    input  logic [`FRAISE_RES_W-1:0]   precision_i,
    output logic                       hit_o
);
    import fraise_infer_pkg::*;

    logic [`FRAISE_RES_W-1:0] abs_diff;

    // unsigned distance, no wrap
    assign abs_diff = (result_i >= reference_i) ? result_i - reference_i
                                                : reference_i - result_i;

    always_comb begin
        case (op_i)
            op_eq:   hit_o = (abs_diff <= precision_i);
            op_gt:   hit_o = (result_i > reference_i);
            op_lt:   hit_o = (result_i < reference_i);
            default: hit_o = 1'b0; // min/max resolved across lines
        endcase
    end

endmodule

/* inference/fraise_sequencer.sv */
// inference FSM: line reads on the array pins, settle, serial result capture
`include "fraise_cfg.svh"

module fraise_sequencer (
    input  logic                            clk_i,
    input  logic                            counter_read_reset,
    input  logic                            start_i,
    input  fraise_infer_pkg::obs_vec_t      obs_i,
    input  logic [`FRAISE_LINES-1:0]        bit_out_i,
    output logic                            busy_o,
    output logic                            done_o,
    output fraise_infer_pkg::line_results_t results_o,
    output fraise_infer_pkg::array_ctrl_t   array_ctrl_o
);
    import fraise_infer_pkg::*;

    localparam int unsigned line_w = $clog2(`FRAISE_LINES);
    localparam int unsigned cyc_w = $clog2(`FRAISE_RES_W);
    localparam read_step_e last_step = read_step_e'(`FRAISE_READ_STEPS - 1);
    localparam logic [line_w-1:0] last_line = line_w'(`FRAISE_LINES - 1);

    seq_state_e        state_q;
    read_step_e        step_q;
    logic [line_w-1:0] line_q;
    logic [cyc_w-1:0]  cyc_q; // settle and capture cycle
    logic [cyc_w-1:0]  bit_idx;
    line_results_t     results_q;

    assign bit_idx = cyc_w'(`FRAISE_RES_W - 1) - cyc_q; // msb first

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            state_q   <= seq_idle;
            step_q    <= step_sl_wl_rise;
            line_q    <= '0;
            cyc_q     <= '0;
            results_q <= '0;
        end else begin
            case (state_q)
                seq_idle: begin
                    if (start_i) begin
                        state_q   <= seq_read_lines;
                        step_q    <= step_sl_wl_rise;
                        line_q    <= '0;
                        results_q <= '0;
                    end
                end
                seq_read_lines: begin
                    case (step_q)
                        step_sl_wl_rise: step_q <= step_sl_fall;
                        step_sl_fall:    step_q <= step_wl_high;
                        step_wl_high:    step_q <= step_wl_fall;
                        default:         step_q <= step_sl_wl_rise;
                    endcase
                    if (step_q == last_step) begin
                        line_q <= line_q + 1'b1;
                        if (line_q == last_line) begin
                            state_q <= seq_settle;
                            cyc_q   <= '0;
                        end
                    end
                end
                seq_settle: begin
                    cyc_q <= cyc_q + 1'b1;
                    if (cyc_q == cyc_w'(`FRAISE_SETTLE_CYCLES - 1)) begin
                        state_q <= seq_capture;
                        cyc_q   <= '0;
                    end
                end
                seq_capture: begin
                    for (int l = 0; l < `FRAISE_LINES; l++) begin
                        results_q[l][bit_idx] <= bit_out_i[l];
                    end
                    cyc_q <= cyc_q + 1'b1;
                    if (cyc_q == cyc_w'(`FRAISE_RES_W - 1)) begin
                        state_q <= seq_done;
                    end
                end
                default: state_q <= seq_idle; // done lasts one cycle
            endcase
        end
    end

    // array pins decoded from state and step
    always_comb begin
        array_ctrl_o          = '0;
        array_ctrl_o.instr    = instr_read_mem;
        array_ctrl_o.addr_col = {line_q, 3'b000}; // line index times 8
        array_ctrl_o.addr_row = {2'b00, obs_i[line_q]};
        if (state_q == seq_read_lines) begin
            array_ctrl_o.csl = (step_q == step_sl_wl_rise);
            array_ctrl_o.cwl = (step_q != step_wl_fall);
        end
        if (state_q == seq_settle || state_q == seq_capture) begin
            array_ctrl_o.instr = instr_read_out;
        end
    end

    assign busy_o    = (state_q != seq_idle);
    assign done_o    = (state_q == seq_done);
    assign results_o = results_q;

    assert property (@(posedge clk_i) disable iff (counter_read_reset)
        array_ctrl_o.csl |-> state_q == seq_read_lines)
        else $error("csl high outside line reads");

    assert property (@(posedge clk_i) disable iff (counter_read_reset)
        done_o |=> !done_o)
        else $error("done_o longer than one cycle");

endmodule

/* regs/fraise_regfile.sv */
// register file: bus decode, configuration registers, result-valid flag
// and the one-cycle read response
`include "fraise_cfg.svh"

module fraise_regfile (
    input  logic                            clk_i,
    input  logic                            counter_read_reset,
    input  logic                            req_valid_i,
    input  fraise_bus_pkg::bus_req_t        bus_req_i,
    input  logic                            busy_i,
    input  logic                            done_i,
    input  fraise_infer_pkg::line_results_t results_i,
    input  fraise_infer_pkg::decision_t     decision_i,
    output logic                            ready_o,
    output logic                            resp_valid_o,
    output fraise_bus_pkg::bus_resp_t       bus_resp_o,
    output logic                            start_o,
    output fraise_infer_pkg::obs_vec_t      obs_o,
    output fraise_infer_pkg::comp_cfg_t     comp_cfg_o,
    output logic                            bypass_o,
    output logic                            irq_en_o,
    output logic                            res_valid_o
);
    import fraise_bus_pkg::*;
    import fraise_infer_pkg::*;

    logic                      on_q; // continuous mode
    logic                      launch_q;
    logic                      res_valid_q;
    logic                      irq_en_q;
    logic                      bypass_q;
    logic [`FRAISE_DATA_W-1:0] obs_q;
    comp_cfg_t                 comp_cfg_q;

    logic                      accept;
    logic                      wr;
    logic [`FRAISE_DATA_W-1:0] ben_mask;
    logic [`FRAISE_DATA_W-1:0] rd_data;

    // no new request while a run is active or a response is out
    assign ready_o = !busy_i && !resp_valid_o;
    assign accept  = req_valid_i && ready_o;
    assign wr      = accept && bus_req_i.wen;

    always_comb begin
        for (int b = 0; b < `FRAISE_DATA_W / 8; b++) begin
            ben_mask[b*8 +: 8] = {8{bus_req_i.ben[b]}};
        end
    end

    // read mux, always the value before this access' write
    always_comb begin
        rd_data = '0;
        case (bus_req_i.addr)
            reg_on_off:      rd_data[0] = on_q;
            reg_obs:         rd_data = obs_q;
            reg_launch:      rd_data[0] = launch_q;
            reg_res_valid:   rd_data[0] = res_valid_q;
            reg_res:         rd_data = results_i;
            reg_irq_en:      rd_data[0] = irq_en_q;
            reg_precision:   rd_data = comp_cfg_q.precision;
            reg_comp_instr:  rd_data = comp_cfg_q.op;
            reg_comp_ref:    rd_data = comp_cfg_q.reference;
            reg_comp_result: rd_data[`FRAISE_LINES-1:0] = decision_i;
            reg_comp_bypass: rd_data[0] = bypass_q;
            default:         rd_data = '0; // unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            on_q        <= 1'b0;
            launch_q    <= 1'b0;
            res_valid_q <= 1'b0;
            irq_en_q    <= 1'b0;
            bypass_q    <= 1'b0;
            obs_q       <= '0;
            comp_cfg_q  <= '0;
        end else begin
            if (busy_i) begin
                launch_q <= 1'b0; // run has started
            end
            if (done_i) begin
                res_valid_q <= 1'b1;
            end else if (accept && bus_req_i.addr == reg_res) begin
                res_valid_q <= 1'b0; // result consumed
            end
            if (wr) begin
                case (bus_req_i.addr)
                    reg_on_off:      on_q <= bus_req_i.wdata[0];
                    reg_obs:         obs_q <= bus_req_i.wdata & ben_mask;
                    reg_launch:      launch_q <= bus_req_i.wdata[0];
                    reg_irq_en:      irq_en_q <= bus_req_i.wdata[0];
                    reg_precision:   comp_cfg_q.precision <= bus_req_i.wdata;
                    reg_comp_instr:  comp_cfg_q.op <= bus_req_i.wdata;
                    reg_comp_ref:    comp_cfg_q.reference <= bus_req_i.wdata;
                    reg_comp_bypass: bypass_q <= bus_req_i.wdata[0];
                    default: ; // read-only or unmapped
                endcase
            end
        end
    end

    // response path
    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            bus_resp_o.data <= rd_data;
            bus_resp_o.host <= bus_req_i.host;
        end
    end

    assign start_o     = on_q || launch_q;
    assign obs_o       = {obs_q[26:24], obs_q[18:16], obs_q[10:8], obs_q[2:0]}; // low bits per byte
    assign comp_cfg_o  = comp_cfg_q;
    assign bypass_o    = bypass_q;
    assign irq_en_o    = irq_en_q;
    assign res_valid_o = res_valid_q;

    // each accepted request gets exactly one response beat
    assert property (@(posedge clk_i) disable iff (counter_read_reset)
        resp_valid_o |=> !resp_valid_o)
        else $error("resp_valid_o held for two cycles");

endmodule

/* common/fraise_infer_pkg.sv */
// sequencer states, comparator opcodes, array control pins and result types
package fraise_infer_pkg;

`include "fraise_cfg.svh"

    typedef enum logic [2:0] {
        seq_idle,
        seq_read_lines,
        seq_settle,
        seq_capture,
        seq_done
    } seq_state_e;

    // one array line read takes these four steps
    typedef enum logic [1:0] {
        step_sl_wl_rise,
        step_sl_fall,
        step_wl_high,
        step_wl_fall
    } read_step_e;

    typedef enum logic [1:0] {
        instr_read_mem = 2'b00,
        instr_read_out = 2'b01
    } array_instr_e;

    typedef enum logic [7:0] {
        op_eq  = 8'd0, // within precision
        op_gt  = 8'd1,
        op_lt  = 8'd2,
        op_min = 8'd3, // taken from line 0 only
        op_max = 8'd4
    } comp_op_e;

    typedef struct packed {
        logic                          csl;
        logic                          cwl;
        array_instr_e                  instr;
        logic [`FRAISE_ADDR_COL_W-1:0] addr_col;
        logic [`FRAISE_ADDR_ROW_W-1:0] addr_row;
    } array_ctrl_t;

    typedef logic [`FRAISE_LINES-1:0][`FRAISE_RES_W-1:0] line_results_t;
    typedef logic [`FRAISE_LINES-1:0][`FRAISE_OBS_W-1:0] obs_vec_t;
    typedef logic [`FRAISE_LINES-1:0]                    decision_t;

    // one byte per line in each field, same layout as the registers
    typedef struct packed {
        logic [`FRAISE_LINES-1:0][7:0] op;
        logic [`FRAISE_LINES-1:0][7:0] reference;
        logic [`FRAISE_LINES-1:0][7:0] precision;
    } comp_cfg_t;

endpackage

/* common/fraise_bus_pkg.sv */
// bus request/response structs and the register offset enum
package fraise_bus_pkg;

`include "fraise_cfg.svh"

    typedef struct packed {
        logic [`FRAISE_ADDR_W-1:0]   addr;
        logic                        wen;   // 1 = write
        logic [`FRAISE_DATA_W-1:0]   wdata;
        logic [`FRAISE_DATA_W/8-1:0] ben;
        logic [`FRAISE_HOST_W-1:0]   host;  // initiator id, echoed back
    } bus_req_t;

    typedef struct packed {
        logic [`FRAISE_DATA_W-1:0] data;
        logic [`FRAISE_HOST_W-1:0] host;
    } bus_resp_t;

    typedef enum logic [`FRAISE_ADDR_W-1:0] {
        reg_on_off      = `FRAISE_REG_ON_OFF,
        reg_obs         = `FRAISE_REG_OBS,
        reg_launch      = `FRAISE_REG_LAUNCH,
        reg_res_valid   = `FRAISE_REG_RES_VALID,
        reg_res         = `FRAISE_REG_RES,
        reg_irq_en      = `FRAISE_REG_IRQ_EN,
        reg_precision   = `FRAISE_REG_PRECISION,
        reg_comp_instr  = `FRAISE_REG_COMP_INSTR,
        reg_comp_ref    = `FRAISE_REG_COMP_REF,
        reg_comp_result = `FRAISE_REG_COMP_RESULT,
        reg_comp_bypass = `FRAISE_REG_COMP_BYPASS
    } reg_addr_e;

endpackage

/* common/fraise_cfg.svh */
// widths, register offsets and read sequence lengths of the inference controller
`ifndef FRAISE_CFG_SVH
`define FRAISE_CFG_SVH

// bus
`define FRAISE_DATA_W 32
`define FRAISE_ADDR_W 32
`define FRAISE_HOST_W 1

// matrix and array
`define FRAISE_LINES      4
`define FRAISE_RES_W      8 // log-probability per line
`define FRAISE_OBS_W      3
`define FRAISE_ADDR_COL_W 5
`define FRAISE_ADDR_ROW_W 5

// read sequence
`define FRAISE_READ_STEPS    4 // csl/cwl steps per line
`define FRAISE_SETTLE_CYCLES 3 // read_out cycles before the first bit

// register map, base 0x10
`define FRAISE_REG_ON_OFF      32'h0000_0010
`define FRAISE_REG_OBS         32'h0000_0018
`define FRAISE_REG_LAUNCH      32'h0000_0020
`define FRAISE_REG_RES_VALID   32'h0000_0024
`define FRAISE_REG_RES         32'h0000_0028
`define FRAISE_REG_IRQ_EN      32'h0000_0030
`define FRAISE_REG_PRECISION   32'h0000_0034
`define FRAISE_REG_COMP_INSTR  32'h0000_0038
`define FRAISE_REG_COMP_REF    32'h0000_003C
`define FRAISE_REG_COMP_RESULT 32'h0000_0040
`define FRAISE_REG_COMP_BYPASS 32'h0000_0044

`endif
